// File: spix_pkg.sv
////////////////////
// Shared widths, frame constants, bus and pin bundles for the SPI flash
// read controller. Every design file refers to these by scoped name
////////////////////
`default_nettype none

package spix_pkg;

	// Widths with a meaning of their own
	typedef logic [21:0] spix_addr_t;
	typedef logic [31:0] spix_word_t;
	typedef logic [7:0]  spix_byte_t;
	typedef logic [6:0]  spix_bitcnt_t;

	// Flash read command, sent right after the lead-in bit
	localparam spix_byte_t   SPIX_READ_CMD  = 8'h03;
	// Lead-in, command, address, two pad bits, 32 data bits
	localparam spix_bitcnt_t SPIX_READ_BITS = 7'd65;
	// Lead-in plus one user byte
	localparam spix_bitcnt_t SPIX_CFG_BITS  = 7'd9;
	// Chip select bit of the configuration word
	localparam integer       SPIX_CSN_BIT   = 8;
	// Outgoing shift register, lead-in through the pad bits
	localparam integer       SPIX_FRAME_W   = 33;

	// Kind of frame to be clocked out
	typedef enum logic {XFER_READ, XFER_CFG} spix_xfer_e;

	// Controller states
	typedef enum logic [2:0] {ST_IDLE, ST_READ, ST_CFG, ST_USER, ST_ACK} spix_state_e;

	// Bus request, master to controller
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       cfg_stb;
		logic       we;
		spix_addr_t addr;
		spix_word_t data;
	} spix_bus_req_t;

	// Bus response, controller to master
	typedef struct packed {
		logic       stall;
		logic       ack;
		spix_word_t data;
	} spix_bus_rsp_t;

	// Outgoing SPI pins
	typedef struct packed {
		logic cs_n;
		logic sck;
		logic mosi;
	} spix_spi_out_t;

endpackage

`default_nettype wire

// File: spix_ctrl_fsm.sv
////////////////////
// Request decoder and control FSM. Sorts accepted requests into read
// frames, byte frames, releases and immediate acks, and owns chip select,
// user mode, stall and ack
////////////////////
`default_nettype none
`timescale 1ns/1ps

module spix_ctrl_fsm (
	input  wire                     i_clk,
	input  wire                     i_reset,
	input  wire spix_pkg::spix_bus_req_t i_req,
	input  wire                     i_last,
	output logic                    o_stall,
	output logic                    o_ack,
	output logic                    o_cs_n,
	output logic                    o_start,
	output spix_pkg::spix_xfer_e    o_kind,
	output logic                    o_user_mode
);

	spix_pkg::spix_state_e state;
	spix_pkg::spix_state_e rest_state;
	logic                  req_valid;
	logic                  is_read;
	logic                  is_byte;
	logic                  is_release;
	// Last-bit strobe delayed to line up with the final capture
	logic [1:0]            last_q;

	////////////////////
	// Request decode
	////////////////////
	// Busy only while a frame is on the wire
	assign o_stall = (state == spix_pkg::ST_READ) || (state == spix_pkg::ST_CFG);
	assign o_ack = (state == spix_pkg::ST_ACK);
	assign req_valid = i_req.cyc && (i_req.stb || i_req.cfg_stb) && !o_stall;

	// Memory read, only outside user mode
	assign is_read = i_req.stb && !i_req.we && !o_user_mode;
	// User byte, chip select bit low
	assign is_byte = i_req.cfg_stb && i_req.we && !i_req.data[spix_pkg::SPIX_CSN_BIT];
	// Leave user mode, chip select bit high
	assign is_release = i_req.cfg_stb && i_req.we && i_req.data[spix_pkg::SPIX_CSN_BIT];

	// Kick off the counter and shifter in the accept cycle
	assign o_start = req_valid && (is_read || is_byte);
	assign o_kind = i_req.cfg_stb ? spix_pkg::XFER_CFG : spix_pkg::XFER_READ;

	// Where the FSM waits between requests
	assign rest_state = o_user_mode ? spix_pkg::ST_USER : spix_pkg::ST_IDLE;

	////////////////////
	// State, chip select and user mode
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state <= spix_pkg::ST_IDLE;
			o_cs_n <= 1'b1;
			o_user_mode <= 1'b0;
			last_q <= '0;
		end
		else if (!i_req.cyc)
		begin
			// Bus abort, drop the frame and any pending ack
			state <= rest_state;
			last_q <= '0;
			// User mode keeps the flash selected
			if (!o_user_mode)
				o_cs_n <= 1'b1;
		end
		else
		begin
			last_q <= {last_q[0], i_last};
			case (state)
				spix_pkg::ST_IDLE, spix_pkg::ST_USER, spix_pkg::ST_ACK:
				begin
					if (!req_valid)
						state <= rest_state;
					else if (is_read)
					begin
						state <= spix_pkg::ST_READ;
						o_cs_n <= 1'b0;
					end
					else if (is_byte)
					begin
						state <= spix_pkg::ST_CFG;
						o_cs_n <= 1'b0;
						o_user_mode <= 1'b1;
					end
					else
					begin
						// Everything else answers on the next cycle
						state <= spix_pkg::ST_ACK;
						if (is_release)
						begin
							o_cs_n <= 1'b1;
							o_user_mode <= 1'b0;
						end
					end
				end
				spix_pkg::ST_READ:
				begin
					// Read word is complete, deselect the flash
					if (last_q[1])
					begin
						state <= spix_pkg::ST_ACK;
						o_cs_n <= 1'b1;
					end
				end
				spix_pkg::ST_CFG:
				begin
					// Chip select stays low in user mode
					if (last_q[1])
						state <= spix_pkg::ST_ACK;
				end
				default:
					state <= spix_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: spix_bit_counter.sv
////////////////////
// Frame length counter. Loaded on start, it holds sck high for one clock
// per SPI bit and strobes last on the final bit
////////////////////
`default_nettype none
`timescale 1ns/1ps

module spix_bit_counter (
	input  wire                       i_clk,
	input  wire                       i_reset,
	input  wire                       i_abort,
	input  wire                       i_start,
	input  wire spix_pkg::spix_xfer_e i_kind,
	output logic                      o_sck,
	output logic                      o_last
);

	// Bits still to go in the current frame
	spix_pkg::spix_bitcnt_t count;

	always_ff @(posedge i_clk)
	begin
		if (i_reset || i_abort)
			count <= '0;
		else if (i_start)
		begin
			// Frame length from the kind of request
			if (i_kind == spix_pkg::XFER_CFG)
				count <= spix_pkg::SPIX_CFG_BITS;
			else
				count <= spix_pkg::SPIX_READ_BITS;
		end
		else if (count != '0)
			count <= count - 1'b1;
	end

	// One SPI bit per clock while bits remain
	assign o_sck = (count != '0);
	assign o_last = (count == spix_pkg::spix_bitcnt_t'(1));

endmodule

`default_nettype wire

// File: spix_mosi_shift.sv
////////////////////
// Outgoing shift register. Loads the read command and address, or the
// user byte, on start and presents one bit per sck cycle on MOSI
////////////////////
`default_nettype none
`timescale 1ns/1ps

module spix_mosi_shift (
	input  wire                       i_clk,
	input  wire                       i_start,
	input  wire spix_pkg::spix_xfer_e i_kind,
	input  wire spix_pkg::spix_addr_t i_addr,
	input  wire spix_pkg::spix_byte_t i_byte,
	input  wire                       i_sck,
	output logic                      o_mosi
);

	// Leading bit sits at the top
	logic [spix_pkg::SPIX_FRAME_W-1:0] frame;

	always_ff @(posedge i_clk)
	begin
		if (i_start)
		begin
			if (i_kind == spix_pkg::XFER_CFG)
			begin
				// Lead-in, user byte, then idle zeros
				frame <= {1'b0, i_byte, {(spix_pkg::SPIX_FRAME_W - 9){1'b0}}};
			end
			else
			begin
				// Lead-in, command, word address, two pad bits
				frame <= {1'b0, spix_pkg::SPIX_READ_CMD, i_addr, 2'b00};
			end
		end
		else if (i_sck)
		begin
			// Zeros follow once the header is out
			frame <= {frame[spix_pkg::SPIX_FRAME_W-2:0], 1'b0};
		end
	end

	assign o_mosi = frame[spix_pkg::SPIX_FRAME_W-1];

endmodule

`default_nettype wire

// File: spix_miso_capture.sv
////////////////////
// Incoming shift register. Samples MISO the cycle after each sck cycle
// and builds the response word, or a zero-extended byte in user mode
////////////////////
`default_nettype none
`timescale 1ns/1ps

module spix_miso_capture (
	input  wire                  i_clk,
	input  wire                  i_reset,
	input  wire                  i_abort,
	input  wire                  i_sck,
	input  wire                  i_user_mode,
	input  wire                  i_miso,
	output spix_pkg::spix_word_t o_data
);

	// sck as the flash sees it, one clock late
	logic sck_d;

	always_ff @(posedge i_clk)
	begin
		if (i_reset || i_abort)
			sck_d <= 1'b0;
		else
			sck_d <= i_sck;
	end

	always_ff @(posedge i_clk)
	begin
		if (sck_d)
		begin
			// Only the last 8 bits count in user mode
			if (i_user_mode)
				o_data <= {24'h0, o_data[6:0], i_miso};
			else
				o_data <= {o_data[30:0], i_miso};
		end
		else if (i_user_mode)
		begin
			// Hold the byte, clear what is left of a read word
			o_data <= {24'h0, o_data[7:0]};
		end
	end

endmodule

`default_nettype wire

// File: spix_top.sv
////////////////////
// SPI flash read controller top. Bus request in, response out, SPI pins
// to the flash
////////////////////
`default_nettype none
`timescale 1ns/1ps

module spix_top (
	input  wire                           i_clk,
	input  wire                           i_reset,
	input  wire spix_pkg::spix_bus_req_t  i_bus,
	output wire spix_pkg::spix_bus_rsp_t  o_bus,
	output wire spix_pkg::spix_spi_out_t  o_spi,
	input  wire                           i_spi_miso
);

	logic                 start;
	spix_pkg::spix_xfer_e kind;
	logic                 last;
	logic                 user_mode;

	// Request decode, chip select, stall and ack
	spix_ctrl_fsm u_ctrl_fsm (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_req       (i_bus),
		.i_last      (last),
		.o_stall     (o_bus.stall),
		.o_ack       (o_bus.ack),
		.o_cs_n      (o_spi.cs_n),
		.o_start     (start),
		.o_kind      (kind),
		.o_user_mode (user_mode)
	);

	// SPI clock and frame length, cleared when cyc drops
	spix_bit_counter u_bit_counter (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_abort (!i_bus.cyc),
		.i_start (start),
		.i_kind  (kind),
		.o_sck   (o_spi.sck),
		.o_last  (last)
	);

	// Command, address or user byte out
	spix_mosi_shift u_mosi_shift (
		.i_clk   (i_clk),
		.i_start (start),
		.i_kind  (kind),
		.i_addr  (i_bus.addr),
		.i_byte  (i_bus.data[7:0]),
		.i_sck   (o_spi.sck),
		.o_mosi  (o_spi.mosi)
	);

	// Returned bits into the bus data word
	spix_miso_capture u_miso_capture (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_abort     (!i_bus.cyc),
		.i_sck       (o_spi.sck),
		.i_user_mode (user_mode),
		.i_miso      (i_spi_miso),
		.o_data      (o_bus.data)
	);

endmodule

`default_nettype wire

// File: tb_spix_flash_model.sv
////////////////////
// Behavioral SPI flash for the testbench. Records MOSI while selected,
// answers reads from the received address and byte frames with i_byte
////////////////////
`default_nettype none
`timescale 1ns/1ps

module tb_spix_flash_model (
	input  wire                          i_clk,
	input  wire spix_pkg::spix_spi_out_t i_spi,
	input  wire spix_pkg::spix_byte_t    i_byte,
	output logic                         o_miso,
	output logic                         o_bad_cmd,
	output spix_pkg::spix_addr_t         o_rx_addr,
	output spix_pkg::spix_byte_t         o_rx_byte
);

	// Frame bits in arrival order, newest at bit 0
	logic [64:0]          rx_bits;
	int                   bit_idx;
	spix_pkg::spix_word_t rd_word;

	initial
	begin
		o_miso = 1'b0;
		o_bad_cmd = 1'b0;
		o_rx_addr = '0;
		o_rx_byte = '0;
		rx_bits = '0;
		bit_idx = 0;
		rd_word = '0;
	end

	always @(posedge i_clk)
	begin
		if (!i_spi.cs_n && i_spi.sck)
		begin
			rx_bits = {rx_bits[63:0], i_spi.mosi};
			// Answer goes out in the cycle after the sck cycle
			if (bit_idx >= 1 && bit_idx <= 8)
				o_miso <= i_byte[8 - bit_idx];
			else if (bit_idx >= 33 && bit_idx <= 64)
				o_miso <= rd_word[64 - bit_idx];
			else
				o_miso <= 1'b0;
			// Address is complete after bit 30
			if (bit_idx == 30)
			begin
				o_rx_addr <= rx_bits[21:0];
				rd_word = {~rx_bits[9:0], rx_bits[21:0]};
			end
			bit_idx = bit_idx + 1;
		end
		else
		begin
			o_miso <= 1'b0;
			// Frame ended, lead-in then the 03 read command at the top
			if (bit_idx == 65 && (rx_bits[64] || rx_bits[63:56] != 8'h03))
				o_bad_cmd <= 1'b1;
			if (bit_idx == 9)
				o_rx_byte <= rx_bits[7:0];
			// Aborted frames are simply dropped
			bit_idx = 0;
		end
	end

endmodule

`default_nettype wire

// File: tb_spix_sva.sv
////////////////////
// Concurrent checks on the controller pins, bound into spix_top
////////////////////
`default_nettype none
`timescale 1ns/1ps

module tb_spix_sva (
	input wire                          i_clk,
	input wire                          i_reset,
	input wire spix_pkg::spix_bus_rsp_t i_rsp,
	input wire spix_pkg::spix_spi_out_t i_spi
);

	// Failures seen so far, read by the testbench at the end
	int unsigned fail_count = 0;

	// No clock to a deselected flash
	a_sck_selected: assert property (@(posedge i_clk) disable iff (i_reset)
		i_spi.sck |-> !i_spi.cs_n)
	else
	begin
		fail_count++;
		$error("sck high while cs_n is high");
	end

	// Stalled and done at once makes no sense
	a_ack_stall: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_rsp.ack && i_rsp.stall))
	else
	begin
		fail_count++;
		$error("ack and stall high together");
	end

	// Quiet outputs after reset
	a_reset_state: assert property (@(posedge i_clk)
		i_reset |=> (i_spi.cs_n && !i_rsp.ack))
	else
	begin
		fail_count++;
		$error("cs_n low or ack high after reset");
	end

endmodule

bind spix_top tb_spix_sva u_sva (
	.i_clk   (i_clk),
	.i_reset (i_reset),
	.i_rsp   (o_bus),
	.i_spi   (o_spi)
);

`default_nettype wire

// File: tb_spix_top.sv
////////////////////
// Testbench for the SPI flash read controller. Applies a table of bus
// requests against a behavioral flash and checks data, timing and pins
////////////////////
`default_nettype none
`timescale 1ns/1ps

module tb_spix_top;

	typedef enum logic [2:0] {OP_READ, OP_BYTE, OP_RELEASE, OP_MWRITE, OP_ABORT} op_e;

	// One table entry, request plus what must come back
	typedef struct packed {
		op_e                  op;
		spix_pkg::spix_word_t arg;
		spix_pkg::spix_byte_t flash_byte;
		spix_pkg::spix_word_t exp_data;
		logic                 chk_data;
		logic                 quick;
		logic                 exp_cs_n;
	} entry_t;

	logic                    clk;
	logic                    reset;
	spix_pkg::spix_bus_req_t bus_req;
	spix_pkg::spix_bus_rsp_t bus_rsp;
	spix_pkg::spix_spi_out_t spi;
	logic                    miso;
	spix_pkg::spix_byte_t    flash_byte;
	logic                    bad_cmd;
	spix_pkg::spix_addr_t    rx_addr;
	spix_pkg::spix_byte_t    rx_byte;
	entry_t                  steps[$];
	logic [31:0]             rand_state = 32'h5258;
	int                      value_errs = 0;
	int                      other_errs = 0;
	logic                    timed_out = 1'b0;
	int                      ack_limit = 4 * spix_pkg::SPIX_READ_BITS;

	spix_top i_spix_top (
		.i_clk      (clk),
		.i_reset    (reset),
		.i_bus      (bus_req),
		.o_bus      (bus_rsp),
		.o_spi      (spi),
		.i_spi_miso (miso)
	);

	tb_spix_flash_model u_flash (
		.i_clk     (clk),
		.i_spi     (spi),
		.i_byte    (flash_byte),
		.o_miso    (miso),
		.o_bad_cmd (bad_cmd),
		.o_rx_addr (rx_addr),
		.o_rx_byte (rx_byte)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// LCG step, upper bits give the word address
	function automatic spix_pkg::spix_addr_t next_addr();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state[31:10];
	endfunction

	// Flash answer, inverted low 10 address bits then the address
	function automatic spix_pkg::spix_word_t flash_word(input spix_pkg::spix_addr_t addr);
		return {~addr[9:0], addr};
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("** Error %s: got %h expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	task automatic add_step(input op_e op, input logic [31:0] arg, input logic [7:0] fbyte,
			input logic [31:0] exp, input logic chk, input logic quick, input logic cs_n);
		steps.push_back('{op, arg, fbyte, exp, chk, quick, cs_n});
	endtask

	task automatic add_random_read();
		spix_pkg::spix_addr_t addr;
		addr = next_addr();
		add_step(OP_READ, {10'h0, addr}, 8'h00, flash_word(addr), 1'b1, 1'b0, 1'b1);
	endtask

	////////////////////
	// Abort in the middle of a read
	////////////////////
	task automatic check_abort();
		for (int i = 0; i < 20; i++)
		begin
			compare("ack", bus_rsp.ack, 1'b0);
			@(negedge clk);
		end
		bus_req.cyc = 1'b0;
		@(negedge clk);
		compare("cs_n", spi.cs_n, 1'b1);
		compare("sck", spi.sck, 1'b0);
		// No late ack may show up
		for (int i = 0; i < 4; i++)
		begin
			compare("ack", bus_rsp.ack, 1'b0);
			@(negedge clk);
		end
	endtask

	////////////////////
	// One table entry, called on a falling edge
	////////////////////
	task automatic run_entry(input entry_t e, input int idx);
		int cycles;
		int sck_seen;
		int stall_seen;
		int exp_cycles;
		flash_byte = e.flash_byte;
		bus_req = '0;
		bus_req.cyc = 1'b1;
		bus_req.we = (e.op == OP_BYTE) || (e.op == OP_RELEASE) || (e.op == OP_MWRITE);
		bus_req.cfg_stb = (e.op == OP_BYTE) || (e.op == OP_RELEASE);
		bus_req.stb = !bus_req.cfg_stb;
		bus_req.addr = e.arg[21:0];
		bus_req.data = e.arg;
		// Idle controller takes the request on the next rising edge
		@(negedge clk);
		bus_req.stb = 1'b0;
		bus_req.cfg_stb = 1'b0;
		if (e.op == OP_ABORT)
		begin
			check_abort();
			return;
		end
		cycles = 1;
		sck_seen = 0;
		stall_seen = 0;
		while (!bus_rsp.ack && cycles < ack_limit)
		begin
			if (spi.sck)
				sck_seen++;
			if (bus_rsp.stall)
				stall_seen++;
			@(negedge clk);
			cycles++;
		end
		if (!bus_rsp.ack)
		begin
			$display("Entry %0d got no ack within %0d cycles", idx, ack_limit);
			other_errs++;
			timed_out = 1'b1;
			return;
		end
		// Frame length plus two capture cycles plus the ack cycle
		if (e.quick)
			exp_cycles = 1;
		else if (e.op == OP_READ)
			exp_cycles = 65 + 3;
		else
			exp_cycles = 9 + 3;
		compare("ack_latency", cycles, exp_cycles);
		compare("sck_cycles", sck_seen, e.quick ? 0 : exp_cycles - 3);
		// Stall covers every cycle before ack and is low with ack
		compare("stall_cycles", stall_seen, exp_cycles - 1);
		compare("stall", bus_rsp.stall, 1'b0);
		compare("cs_n", spi.cs_n, e.exp_cs_n);
		if (e.chk_data)
			compare("data", bus_rsp.data, e.exp_data);
		if (e.op == OP_READ && !e.quick)
		begin
			compare("rx_addr", rx_addr, e.arg[21:0]);
			if (bad_cmd)
			begin
				$display("Flash model saw a wrong lead-in or read command in entry %0d", idx);
				other_errs++;
			end
		end
		if (e.op == OP_BYTE)
			compare("rx_byte", rx_byte, e.arg[7:0]);
		bus_req.cyc = 1'b0;
		@(negedge clk);
		// Ack is a single pulse
		compare("ack", bus_rsp.ack, 1'b0);
	endtask

	initial
	begin
		reset = 1'b1;
		bus_req = '0;
		flash_byte = '0;
		add_random_read();
		add_random_read();
		// User byte out, flash answers 3C, chip select held
		add_step(OP_BYTE, 32'h0A5, 8'h3C, 32'h3C, 1'b1, 1'b0, 1'b0);
		add_step(OP_READ, 32'h0, 8'h00, 32'h3C, 1'b1, 1'b1, 1'b0);
		add_step(OP_BYTE, 32'h05A, 8'hC3, 32'hC3, 1'b1, 1'b0, 1'b0);
		add_step(OP_RELEASE, 32'h100, 8'h00, 32'h0, 1'b0, 1'b1, 1'b1);
		add_random_read();
		add_step(OP_MWRITE, 32'h1234, 8'h00, 32'h0, 1'b0, 1'b1, 1'b1);
		add_step(OP_ABORT, {10'h0, next_addr()}, 8'h00, 32'h0, 1'b0, 1'b0, 1'b1);
		add_random_read();
		add_random_read();
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		for (int i = 0; i < steps.size() && !timed_out; i++)
			run_entry(steps[i], i);
		$display("Value errors %0d, other errors %0d, assertion failures %0d",
			value_errs, other_errs, i_spix_top.u_sva.fail_count);
		if (value_errs + other_errs + i_spix_top.u_sva.fail_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
spix_pkg.sv
spix_ctrl_fsm.sv
spix_bit_counter.sv
spix_mosi_shift.sv
spix_miso_capture.sv
spix_top.sv
tb_spix_flash_model.sv
tb_spix_sva.sv
tb_spix_top.sv
